// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_isa_pkg.sv
  - rv_pipe_pkg.sv
  - reg_file.sv
  - alu.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_checker.sv
      - tb_rv_core.sv

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module alu
(
    input  wire [`XLEN-1:0]   a,
    input  wire [`XLEN-1:0]   b,
    input  wire rv_pipe_pkg::alu_op_e op,
    output logic [`XLEN-1:0]  result
);

    // shift amount from the low bits of b
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            rv_pipe_pkg::alu_add:
                result = a + b;
            rv_pipe_pkg::alu_sub:
                result = a - b;
            rv_pipe_pkg::alu_sll:
                result = a << shamt;
            // compares yield 0 or 1
            rv_pipe_pkg::alu_slt:
                result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pipe_pkg::alu_sltu:
                result = {{(`XLEN-1){1'b0}}, a < b};
            rv_pipe_pkg::alu_xor:
                result = a ^ b;
            rv_pipe_pkg::alu_srl:
                result = a >> shamt;
            // arithmetic, sign bit fills in
            rv_pipe_pkg::alu_sra:
                result = $signed(a) >>> shamt;
            rv_pipe_pkg::alu_or:
                result = a | b;
            rv_pipe_pkg::alu_and:
                result = a & b;
            // lui, immediate already shifted
            rv_pipe_pkg::alu_pass_b:
                result = b;
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module decode_stage
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire rv_pipe_pkg::if_id_t if_id,
    input  wire rv_pipe_pkg::mem_wb_t wb,
    output logic                     stall,
    output rv_pipe_pkg::id_ex_t      id_ex
);

    rv_isa_pkg::inst_u      inst;
    rv_pipe_pkg::ctrl_t     ctrl;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`REG_ADDR_W-1:0] rs1_m;
    logic [`REG_ADDR_W-1:0] rs2_m;

    // funct3 plus the alt bit to alu op
    function automatic rv_pipe_pkg::alu_op_e alu_op_of(
        input rv_isa_pkg::funct3_e f3,
        input logic                alt
    );
        case (f3)
            rv_isa_pkg::f3_add_sub:
                alu_op_of = alt ? rv_pipe_pkg::alu_sub : rv_pipe_pkg::alu_add;
            rv_isa_pkg::f3_sll:
                alu_op_of = rv_pipe_pkg::alu_sll;
            rv_isa_pkg::f3_slt:
                alu_op_of = rv_pipe_pkg::alu_slt;
            rv_isa_pkg::f3_sltu:
                alu_op_of = rv_pipe_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:
                alu_op_of = rv_pipe_pkg::alu_xor;
            rv_isa_pkg::f3_srl_sra:
                alu_op_of = alt ? rv_pipe_pkg::alu_sra : rv_pipe_pkg::alu_srl;
            rv_isa_pkg::f3_or:
                alu_op_of = rv_pipe_pkg::alu_or;
            default:
                alu_op_of = rv_pipe_pkg::alu_and;
        endcase
    endfunction

    assign inst = if_id.inst;

    // ==================================================
    // control decode
    // ==================================================

    always_comb
    begin
        ctrl = '0;
        case (inst.r.opcode)
            rv_isa_pkg::opc_op:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op_of(inst.r.funct3, inst.r.funct7[5]);
            end
            // imm bit 10 means sra only, never sub
            rv_isa_pkg::opc_op_imm:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_op_of(inst.r.funct3, inst.r.funct7[5] &&
                    (inst.r.funct3 == rv_isa_pkg::f3_srl_sra));
            end
            rv_isa_pkg::opc_lui:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = rv_pipe_pkg::alu_pass_b;
            end
            rv_isa_pkg::opc_load:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
            end
            rv_isa_pkg::opc_store:
            begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            default:
                ctrl = '0;
        endcase
        // x0 target never writes
        ctrl.reg_write = ctrl.reg_write && (inst.r.rd != '0);
    end

    // sign-extended immediate per format
    always_comb
    begin
        case (inst.r.opcode)
            rv_isa_pkg::opc_op_imm, rv_isa_pkg::opc_load:
                imm = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
            rv_isa_pkg::opc_store:
                imm = {{(`XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            rv_isa_pkg::opc_lui:
                imm = {inst.u.imm, 12'b0};
            default:
                imm = '0;
        endcase
    end

    // sources zeroed where the format lacks them
    always_comb
    begin
        rs1_m = '0;
        rs2_m = '0;
        case (inst.r.opcode)
            rv_isa_pkg::opc_op, rv_isa_pkg::opc_store:
            begin
                rs1_m = inst.r.rs1;
                rs2_m = inst.r.rs2;
            end
            rv_isa_pkg::opc_op_imm, rv_isa_pkg::opc_load:
                rs1_m = inst.r.rs1;
            default:
                rs1_m = '0;
        endcase
    end

    reg_file u_reg_file
    (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (inst.r.rs1),
        .rs2_addr (inst.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb.reg_write),
        .wr_addr  (wb.rd),
        .wr_data  (wb.data)
    );

    // load in ex whose result is needed next cycle
    assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                   ((id_ex.rd == rs1_m) || (id_ex.rd == rs2_m));

    // ==================================================
    // id/ex register
    // ==================================================

    always_ff @(posedge clk)
    begin
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
        // bubble on reset and on stall
        if (reset || stall)
        begin
            id_ex.ctrl <= '0;
            id_ex.rd   <= '0;
            id_ex.rs1  <= '0;
            id_ex.rs2  <= '0;
        end
        else
        begin
            id_ex.ctrl <= ctrl;
            id_ex.rd   <= inst.r.rd;
            id_ex.rs1  <= rs1_m;
            id_ex.rs2  <= rs2_m;
        end
    end

    // fetch must hold the dependent instruction in id behind the bubble
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(if_id));

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module execute_stage
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire rv_pipe_pkg::id_ex_t  id_ex,
    output rv_pipe_pkg::ex_mem_t      ex_mem,
    input  wire rv_pipe_pkg::mem_wb_t wb
);

    rv_pipe_pkg::fwd_sel_e fwd_a;
    rv_pipe_pkg::fwd_sel_e fwd_b;
    logic [`XLEN-1:0]      op_a;
    logic [`XLEN-1:0]      rs2_val;
    logic [`XLEN-1:0]      op_b;
    logic [`XLEN-1:0]      alu_result;

    // ==================================================
    // forwarding unit
    // ==================================================

    // newest producer first, loads in mem are not ready
    function automatic rv_pipe_pkg::fwd_sel_e fwd_pick(
        input logic [`REG_ADDR_W-1:0] rs,
        input rv_pipe_pkg::ex_mem_t   mem_reg,
        input rv_pipe_pkg::mem_wb_t   wb_reg
    );
        if (mem_reg.reg_write && !mem_reg.mem_read &&
            (mem_reg.rd != '0) && (mem_reg.rd == rs))
            fwd_pick = rv_pipe_pkg::fwd_mem;
        else if (wb_reg.reg_write && (wb_reg.rd != '0) && (wb_reg.rd == rs))
            fwd_pick = rv_pipe_pkg::fwd_wb;
        else
            fwd_pick = rv_pipe_pkg::fwd_reg;
    endfunction

    function automatic logic [`XLEN-1:0] fwd_value(
        input rv_pipe_pkg::fwd_sel_e sel,
        input logic [`XLEN-1:0]      reg_val,
        input logic [`XLEN-1:0]      mem_val,
        input logic [`XLEN-1:0]      wb_val
    );
        case (sel)
            rv_pipe_pkg::fwd_mem:
                fwd_value = mem_val;
            rv_pipe_pkg::fwd_wb:
                fwd_value = wb_val;
            default:
                fwd_value = reg_val;
        endcase
    endfunction

    assign fwd_a = fwd_pick(id_ex.rs1, ex_mem, wb);
    assign fwd_b = fwd_pick(id_ex.rs2, ex_mem, wb);

    assign op_a    = fwd_value(fwd_a, id_ex.rs1_data, ex_mem.alu_result, wb.data);
    // forwarded rs2 doubles as store data
    assign rs2_val = fwd_value(fwd_b, id_ex.rs2_data, ex_mem.alu_result, wb.data);
    assign op_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_val;

    alu u_alu
    (
        .a      (op_a),
        .b      (op_b),
        .op     (id_ex.ctrl.alu_op),
        .result (alu_result)
    );

    // ==================================================
    // ex/mem register
    // ==================================================

    always_ff @(posedge clk)
    begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rs2_val;
        if (reset)
        begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.rd        <= '0;
        end
        else
        begin
            ex_mem.reg_write <= id_ex.ctrl.reg_write;
            ex_mem.mem_read  <= id_ex.ctrl.mem_read;
            ex_mem.mem_write <= id_ex.ctrl.mem_write;
            ex_mem.rd        <= id_ex.rd;
        end
    end

    // load-use stall must keep the consumer out of the mem path
    a_no_load_fwd: assert property (@(posedge clk) disable iff (reset)
        (ex_mem.mem_read && (ex_mem.rd != '0))
        |-> ((id_ex.rs1 != ex_mem.rd) && (id_ex.rs2 != ex_mem.rd)));

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module fetch_stage
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       stall,
    output logic [`IMEM_ADDR_W-1:0]   imem_addr,
    input  wire [`XLEN-1:0]           imem_data,
    output rv_pipe_pkg::if_id_t       if_id
);

    // byte address, always word aligned
    logic [`XLEN-1:0] pc;

    // ==================================================
    // program counter
    // ==================================================

    // no branches, so only +4 or hold
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= '0;
        else if (!stall)
            pc <= pc + `XLEN'd4;
    end

    // word index into the external rom
    assign imem_addr = pc[`IMEM_ADDR_W+1:2];

    // ==================================================
    // if/id register
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            if_id.inst <= rv_isa_pkg::inst_u'(`RV_NOP);
            if_id.pc   <= '0;
        end
        // stall keeps the dependent instruction in id
        else if (!stall)
        begin
            if_id.inst <= rv_isa_pkg::inst_u'(imem_data);
            if_id.pc   <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module memory_stage
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire rv_pipe_pkg::ex_mem_t  ex_mem,
    output rv_pipe_pkg::mem_wb_t       wb,
    output logic                       wb_valid,
    output logic [`REG_ADDR_W-1:0]     wb_rd,
    output logic [`XLEN-1:0]           wb_data
);

    logic [`XLEN-1:0]        dmem [0:(1 << `DMEM_ADDR_W) - 1];
    logic [`DMEM_ADDR_W-1:0] dmem_addr;
    logic [`XLEN-1:0]        load_data;

    // ==================================================
    // data ram
    // ==================================================

    initial
    begin
        for (int k = 0; k < (1 << `DMEM_ADDR_W); k++)
            dmem[k] = '0;
    end

    // word addressed, byte offset dropped
    assign dmem_addr = ex_mem.alu_result[`DMEM_ADDR_W+1:2];

    // store lands at the end of its mem cycle
    always_ff @(posedge clk)
    begin
        if (ex_mem.mem_write)
            dmem[dmem_addr] <= ex_mem.store_data;
    end

    // async read
    assign load_data = dmem[dmem_addr];

    // ==================================================
    // mem/wb register
    // ==================================================

    always_ff @(posedge clk)
    begin
        wb.data <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        if (reset)
        begin
            wb.reg_write <= 1'b0;
            wb.rd        <= '0;
        end
        else
        begin
            wb.reg_write <= ex_mem.reg_write;
            wb.rd        <= ex_mem.rd;
        end
    end

    // retire port
    assign wb_valid = wb.reg_write && (wb.rd != '0);
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

    // store never writes a register
    a_store_no_write: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.mem_write && ex_mem.reg_write));

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module reg_file
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire [`REG_ADDR_W-1:0]  rs1_addr,
    input  wire [`REG_ADDR_W-1:0]  rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  wire                    wr_en,
    input  wire [`REG_ADDR_W-1:0]  wr_addr,
    input  wire [`XLEN-1:0]        wr_data
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W) - 1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int k = 1; k < (1 << `REG_ADDR_W); k++)
                regs[k] <= '0;
        end
        else if (wr_en && (wr_addr != '0))
            regs[wr_addr] <= wr_data;
    end

    // read port, write-through when wb hits the same entry
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_en && (wr_addr == rs1_addr)) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_en && (wr_addr == rs2_addr)) ? wr_data : regs[rs2_addr];

    // decode must strip reg_write for rd of zero
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (wr_addr != '0));

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_core
(
    input  wire                       clk,
    input  wire                       reset,
    output logic [`IMEM_ADDR_W-1:0]   imem_addr,
    input  wire [`XLEN-1:0]           imem_data,
    output logic                      wb_valid,
    output logic [`REG_ADDR_W-1:0]    wb_rd,
    output logic [`XLEN-1:0]          wb_data
);

    // load-use hold from decode
    logic                  stall;
    rv_pipe_pkg::if_id_t   if_id;
    rv_pipe_pkg::id_ex_t   id_ex;
    rv_pipe_pkg::ex_mem_t  ex_mem;
    // also feeds reg file write and wb forwarding
    rv_pipe_pkg::mem_wb_t  wb;

    // ==================================================
    // stages
    // ==================================================

    fetch_stage u_fetch
    (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_id     (if_id)
    );

    decode_stage u_decode
    (
        .clk   (clk),
        .reset (reset),
        .if_id (if_id),
        .wb    (wb),
        .stall (stall),
        .id_ex (id_ex)
    );

    // ex_mem loops back for mem forwarding
    execute_stage u_execute
    (
        .clk    (clk),
        .reset  (reset),
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .wb     (wb)
    );

    memory_stage u_memory
    (
        .clk      (clk),
        .reset    (reset),
        .ex_mem   (ex_mem),
        .wb       (wb),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// ==== rv_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_core_checker
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire [`IMEM_ADDR_W-1:0] imem_addr,
    input  wire                    wb_valid,
    input  wire [`REG_ADDR_W-1:0]  wb_rd,
    input  wire [`XLEN-1:0]        wb_data
);

    // one expected retire
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } retire_t;

    // program order, filled before the run
    retire_t expect_q [$];

    int retire_count   = 0;
    int mismatch_count = 0;
    int extra_count    = 0;
    int missing_count  = 0;
    int fetch_count    = 0;

    // fetch address at the previous sample
    logic [`IMEM_ADDR_W-1:0] prev_addr;
    logic                    prev_ok = 1'b0;

    // ==================================================
    // queue access from the testbench top
    // ==================================================

    task automatic add_expected(
        input logic [`REG_ADDR_W-1:0] rd,
        input logic [`XLEN-1:0]       data
    );
        retire_t e;
        e.rd   = rd;
        e.data = data;
        expect_q.push_back(e);
    endtask

    function automatic int pending();
        pending = expect_q.size();
    endfunction

    // ==================================================
    // fetch address check
    // ==================================================

    // starts at word zero, then steps one word or holds on a stall
    always @(negedge clk)
    begin
        if (reset)
            prev_ok = 1'b0;
        else
        begin
            if (!prev_ok && (imem_addr != '0))
            begin
                fetch_count++;
                $display("mismatch at %0t: fetch address %0d out of reset, expected 0",
                    $time, imem_addr);
            end
            else if (prev_ok && (imem_addr != prev_addr) &&
                     (imem_addr != prev_addr + 1'b1))
            begin
                fetch_count++;
                $display("mismatch at %0t: fetch address %0d after %0d, expected hold or +1",
                    $time, imem_addr, prev_addr);
            end
            prev_addr = imem_addr;
            prev_ok   = 1'b1;
        end
    end

    // ==================================================
    // retire compare
    // ==================================================

    // mid-cycle sample, retire outputs settled
    always @(negedge clk)
    begin
        retire_t e;
        if (!reset && wb_valid)
        begin
            retire_count++;
            if (expect_q.size() == 0)
            begin
                extra_count++;
                $display("error at %0t: x%0d retired but no register write was expected",
                    $time, wb_rd);
            end
            else
            begin
                e = expect_q.pop_front();
                // rd and data both must match
                if ((e.rd != wb_rd) || (e.data != wb_data))
                begin
                    mismatch_count++;
                    $display("mismatch at %0t: retired x%0d = 0x%08h, expected x%0d = 0x%08h",
                        $time, wb_rd, wb_data, e.rd, e.data);
                end
            end
        end
    end

    // leftovers and the count line
    task automatic close_out(output int total);
        missing_count = expect_q.size();
        if (missing_count != 0)
            $display("error: %0d expected register writes never retired, next is x%0d",
                missing_count, expect_q[0].rd);
        $display("done: %0d retired, %0d mismatches, %0d unexpected, %0d missing, %0d bad pc",
            retire_count, mismatch_count, extra_count, missing_count, fetch_count);
        total = mismatch_count + extra_count + missing_count + fetch_count;
    endtask

endmodule

`default_nettype wire

// ==== rv_isa_pkg.sv ====
`default_nettype none
`include "rv_params.svh"

package rv_isa_pkg;

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_e;

    // alu funct3, shared by op and op_imm
    typedef enum logic [2:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_e;

    // ==================================================
    // instruction formats, msb first
    // ==================================================

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e                funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e                funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } i_type_t;

    // store offset split around rs2
    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e                funct3;
        logic [4:0]             imm_lo;
        opcode_e                opcode;
    } s_type_t;

    typedef struct packed {
        logic [19:0]            imm;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } u_type_t;

    // one fetched word, four views
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        u_type_t u;
    } inst_u;

endpackage

`default_nettype wire

// ==== rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// ==================================================
// core widths
// ==================================================

// data word width
`define XLEN 32
// register index width
`define REG_ADDR_W 5

// word address bits of the data RAM
`define DMEM_ADDR_W 10
// word address bits on the fetch port
`define IMEM_ADDR_W 10

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== rv_pipe_pkg.sv ====
`default_nettype none
`include "rv_params.svh"

package rv_pipe_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // operand source in ex
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_e;

    // decoded control, all zero is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    alu_src_imm;
        alu_op_e alu_op;
        logic    mem_read;
        logic    mem_write;
    } ctrl_t;

    // ==================================================
    // pipeline registers
    // ==================================================

    typedef struct packed {
        rv_isa_pkg::inst_u inst;
        logic [`XLEN-1:0]  pc;
    } if_id_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
    } id_ex_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic [`XLEN-1:0]       alu_result;
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    // data is final, load already selected
    typedef struct packed {
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== sim.f ====
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
reg_file.sv
alu.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
rv_core.sv
rv_core_checker.sv
tb_rv_core.sv

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module tb_rv_core;

    // random program length and run limit
    localparam int PROG_LEN       = 200;
    localparam int TIMEOUT_CYCLES = 2 * PROG_LEN + 20;
    // retires still possible once the queue is empty
    localparam int DRAIN_CYCLES   = 8;

    // one register write predicted by the model
    typedef struct packed {
        logic                   wr;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } exp_wr_t;

    logic                    clk;
    logic                    reset;
    logic [`IMEM_ADDR_W-1:0] imem_addr;
    logic [`XLEN-1:0]        imem_data;
    logic                    wb_valid;
    logic [`REG_ADDR_W-1:0]  wb_rd;
    logic [`XLEN-1:0]        wb_data;

    logic [`XLEN-1:0] rom [0:PROG_LEN-1];
    // architectural model, x0 never written
    logic [`XLEN-1:0] model_regs [0:31];
    // 16-word load/store window
    logic [`XLEN-1:0] model_mem [0:15];

    int cycle_count;
    int final_errs;

    // ==================================================
    // clock, dut, checker
    // ==================================================

    initial
        clk = 1'b0;

    always #4 clk = ~clk;

    // instruction rom, nop past the program
    assign imem_data = (imem_addr < PROG_LEN) ? rom[imem_addr] : `RV_NOP;

    rv_core i_dut
    (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    rv_core_checker i_checker
    (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    // ==================================================
    // reference model
    // ==================================================

    // integer ops per the isa, alt selects sub or sra
    function automatic logic [`XLEN-1:0] alu_ref(
        input logic [2:0]       f3,
        input logic             alt,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        logic [4:0] sh;
        sh = b[4:0];
        alu_ref = '0;
        case (f3)
            3'd0:
                alu_ref = alt ? (a - b) : (a + b);
            3'd1:
                alu_ref = a << sh;
            3'd2:
                alu_ref = {31'b0, $signed(a) < $signed(b)};
            3'd3:
                alu_ref = {31'b0, a < b};
            3'd4:
                alu_ref = a ^ b;
            3'd5:
            begin
                // kept apart so the shift stays signed
                if (alt)
                    alu_ref = $signed(a) >>> sh;
                else
                    alu_ref = a >> sh;
            end
            3'd6:
                alu_ref = a | b;
            default:
                alu_ref = a & b;
        endcase
    endfunction

    // run one word on the model, report the write it makes
    function automatic exp_wr_t ref_step(input logic [`XLEN-1:0] w);
        exp_wr_t          res;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [2:0]       f3;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] addr;
        rd    = w[11:7];
        f3    = w[14:12];
        rs1   = w[19:15];
        rs2   = w[24:20];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        res   = '0;
        res.rd = rd;
        case (w[6:0])
            7'h33:
            begin
                res.wr   = 1'b1;
                res.data = alu_ref(f3, w[30], model_regs[rs1], model_regs[rs2]);
            end
            // bit 30 only picks srai among the immediates
            7'h13:
            begin
                res.wr   = 1'b1;
                res.data = alu_ref(f3, w[30] && (f3 == 3'd5), model_regs[rs1], imm_i);
            end
            7'h37:
            begin
                res.wr   = 1'b1;
                res.data = {w[31:12], 12'b0};
            end
            7'h03:
            begin
                addr     = model_regs[rs1] + imm_i;
                res.wr   = 1'b1;
                res.data = model_mem[addr[5:2]];
            end
            7'h23:
            begin
                addr = model_regs[rs1] + imm_s;
                model_mem[addr[5:2]] = model_regs[rs2];
            end
            default:
                res.wr = 1'b0;
        endcase
        // x0 target is silent
        res.wr = res.wr && (rd != 5'd0);
        if (res.wr)
            model_regs[rd] = res.data;
        ref_step = res;
    endfunction

    // ==================================================
    // random program
    // ==================================================

    task automatic build_program;
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  shamt;
        logic [11:0] imm;
        logic [19:0] uimm;
        logic [3:0]  off;
        logic [3:0]  last_off;
        logic        last_sw;
        logic [31:0] w;
        exp_wr_t     res;
        last_sw  = 1'b0;
        last_off = '0;
        for (int k = 0; k < 32; k++)
            model_regs[k] = '0;
        for (int k = 0; k < 16; k++)
            model_mem[k] = '0;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            // x0..x7 keeps dependencies dense
            rd    = 5'($urandom % 8);
            rs1   = 5'($urandom % 8);
            rs2   = 5'($urandom % 8);
            f3    = 3'($urandom % 8);
            alt   = ((f3 == 3'd0) || (f3 == 3'd5)) ? 1'($urandom % 2) : 1'b0;
            shamt = 5'($urandom % 32);
            imm   = 12'($urandom);
            uimm  = 20'($urandom);
            off   = 4'($urandom % 16);
            kind  = $urandom % 16;
            // half the stores are read straight back
            if (last_sw && (($urandom % 2) == 0))
            begin
                kind = 12;
                off  = last_off;
            end
            if (kind < 6)
                w = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
            else if (kind < 11)
            begin
                if (f3 == 3'd1)
                    imm = {7'h00, shamt};
                else if (f3 == 3'd5)
                    imm = {alt ? 7'h20 : 7'h00, shamt};
                w = {imm, rs1, f3, rd, 7'h13};
            end
            else if (kind == 11)
                w = {uimm, rd, 7'h37};
            else if (kind < 14)
                w = {6'b0, off, 2'b00, 5'd0, 3'b010, rd, 7'h03};
            else
            begin
                imm = {6'b0, off, 2'b00};
                w   = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
            end
            last_sw  = (kind >= 14);
            last_off = off;
            rom[i] = w;
            res    = ref_step(w);
            if (res.wr)
                i_checker.add_expected(res.rd, res.data);
        end
    endtask

    // ==================================================
    // run control
    // ==================================================

    initial
    begin
        reset = 1'b1;
        // one seed for the whole program
        void'($urandom(87186));
        build_program();
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        // done once every predicted write has retired
        while (i_checker.pending() != 0)
            @(posedge clk);
        // catch stray retires behind the last one
        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;
        i_checker.close_out(final_errs);
        if (final_errs == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog, counts cycles out of reset
    always @(posedge clk)
    begin
        if (reset)
            cycle_count = 0;
        else
        begin
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES)
            begin
                $display("timeout: %0d retires still missing after %0d cycles",
                    i_checker.pending(), cycle_count);
                i_checker.close_out(final_errs);
                $display("Simulation failed");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire
